// ==== hdl/router_cfg.svh ====
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// Word is one class bit over five payload bits
`define ROUTER_WORD_W 6

// Words per FIFO
`define ROUTER_DEPTH 8

// Read and write pointer width
`define ROUTER_ADDR_W 3

// Level and threshold width, holds 0 up to ROUTER_DEPTH
`define ROUTER_LVL_W 4

`endif

// ==== hdl/router_pkg.sv ====
`include "router_cfg.svh"

package router_pkg;

	typedef logic [`ROUTER_WORD_W-1:0] word_t;

	typedef logic [`ROUTER_LVL_W-1:0] lvl_t;	// Fill level and thresholds

	typedef enum logic {
		CLASS_0 = 1'b0,
		CLASS_1 = 1'b1
	} word_class_t;

	typedef enum logic [1:0] {
		CTRL_RESET  = 2'd0,
		CTRL_INIT   = 2'd1,
		CTRL_IDLE   = 2'd2,
		CTRL_ACTIVE = 2'd3
	} ctrl_state_t;

	// Class sits in the top bit of the word
	function automatic word_class_t class_of(input word_t w);
		return word_class_t'(w[`ROUTER_WORD_W-1]);
	endfunction

endpackage

// ==== hdl/fifo_status_if.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

interface fifo_status_if import router_pkg::*; ;
	logic empty;
	logic full;
	logic almost_empty;
	logic almost_full;
	logic error;
	lvl_t level;
	lvl_t thr_low;	// Set by the controller
	lvl_t thr_high;

	modport fifo (
		output empty, full, almost_empty, almost_full, error, level,
		input thr_low, thr_high
	);

	modport ctrl (
		input empty, full, almost_empty, almost_full, error, level,
		output thr_low, thr_high
	);

endinterface

// ==== hdl/dual_port_memory.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module dual_port_memory #(
	parameter int DEPTH = `ROUTER_DEPTH,
	parameter int ADDR_W = `ROUTER_ADDR_W
) (
	input  logic clk,
	input  logic wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [`ROUTER_WORD_W-1:0] wr_data,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [`ROUTER_WORD_W-1:0] rd_data
);

	logic [`ROUTER_WORD_W-1:0] mem [DEPTH];

	// Write port on the clock
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Head word is visible with no read latency
	assign rd_data = mem[rd_addr];

endmodule

// ==== hdl/fifo.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module fifo
	import router_pkg::*;
#(
	parameter int DEPTH = `ROUTER_DEPTH
) (
	input  logic clk,
	input  logic reset_L,
	input  logic push,
	input  logic pop,
	input  word_t data_in,
	output word_t data_out,
	fifo_status_if.fifo stat
);

	localparam int ADDR_W = `ROUTER_ADDR_W;
	localparam lvl_t FULL_LVL = lvl_t'(DEPTH);

	typedef logic [ADDR_W-1:0] addr_t;

	addr_t wr_ptr;
	addr_t rd_ptr;
	lvl_t count;
	logic wr_ok;
	logic rd_ok;

	// Pointers wrap at DEPTH, which need not be a power of two
	function automatic addr_t ptr_inc(input addr_t p);
		return (p == addr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Illegal operations are dropped
	assign wr_ok = push && !stat.full;
	assign rd_ok = pop && !stat.empty;

	dual_port_memory #(
		.DEPTH  (DEPTH),
		.ADDR_W (ADDR_W)
	) mem_i (
		.clk     (clk),
		.wr_en   (wr_ok),
		.wr_addr (wr_ptr),
		.wr_data (data_in),
		.rd_addr (rd_ptr),
		.rd_data (data_out)
	);

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
			if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Idle, or push and pop together
			endcase
		end
	end

	// Status flags follow the count directly
	assign stat.level = count;
	assign stat.empty = (count == '0);
	assign stat.full = (count == FULL_LVL);
	assign stat.almost_empty = (count != '0) && (count <= stat.thr_low);
	assign stat.almost_full = (count >= stat.thr_high) && (count < FULL_LVL);

	// One cycle pulse after a push while full or a pop while empty
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			stat.error <= 1'b0;
		end else begin
			stat.error <= (push && stat.full) || (pop && stat.empty);
		end
	end

endmodule

// ==== hdl/class_demux.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module class_demux
	import router_pkg::*;
(
	input  logic clk,
	input  logic reset_L,
	input  word_t head,
	input  logic head_empty,
	output logic head_pop,
	output logic push0,
	output logic push1,
	output word_t word_out,
	input  logic credit_ret0,
	input  logic credit_ret1
);

	localparam lvl_t INIT_CREDIT = lvl_t'(`ROUTER_DEPTH);

	word_class_t head_class;
	lvl_t credit0;	// Free slots in output FIFO 0
	lvl_t credit1;
	logic has_credit;

	// One credit spent per push, one returned per output pop
	function automatic lvl_t credit_next(input lvl_t cnt, input logic take, input logic give);
		case ({take, give})
			2'b10: return cnt - 1'b1;
			2'b01: return cnt + 1'b1;
			default: return cnt;
		endcase
	endfunction

	assign head_class = class_of(head);
	assign has_credit = (head_class == CLASS_1) ? (credit1 != '0) : (credit0 != '0);

	// Head without credit stays put and blocks the words behind it
	assign head_pop = !head_empty && has_credit;
	assign push0 = head_pop && (head_class == CLASS_0);
	assign push1 = head_pop && (head_class == CLASS_1);
	assign word_out = head;	// Both output FIFOs share the data word

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			credit0 <= INIT_CREDIT;
			credit1 <= INIT_CREDIT;
		end else begin
			credit0 <= credit_next(credit0, push0, credit_ret0);
			credit1 <= credit_next(credit1, push1, credit_ret1);
		end
	end

endmodule

// ==== hdl/flow_ctrl.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module flow_ctrl
	import router_pkg::*;
(
	input  logic clk,
	input  logic reset_L,
	input  lvl_t thr_low_in,
	input  lvl_t thr_high_in,
	fifo_status_if.ctrl in_stat,
	fifo_status_if.ctrl out0_stat,
	fifo_status_if.ctrl out1_stat,
	output logic pause,
	output logic active,
	output logic error_fifo
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	lvl_t thr_low_q;
	lvl_t thr_high_q;
	logic any_busy;
	logic any_error;
	logic running;

	assign any_busy = !in_stat.empty || !out0_stat.empty || !out1_stat.empty;
	assign any_error = in_stat.error || out0_stat.error || out1_stat.error;

	always_comb begin
		case (state)
			CTRL_RESET: state_next = CTRL_INIT;
			CTRL_INIT: state_next = CTRL_IDLE;
			default: state_next = any_busy ? CTRL_ACTIVE : CTRL_IDLE;	// Idle and active
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			state <= CTRL_RESET;
			thr_low_q <= '0;
			thr_high_q <= lvl_t'(`ROUTER_DEPTH);	// Keeps almost full quiet until loaded
			error_fifo <= 1'b0;
		end else begin
			state <= state_next;
			if (state == CTRL_RESET) begin
				thr_low_q <= thr_low_in;	// Taken on the edge into init
				thr_high_q <= thr_high_in;
			end
			if (any_error) error_fifo <= 1'b1;	// Sticky until reset
		end
	end

	// Same thresholds go to every FIFO
	assign in_stat.thr_low = thr_low_q;
	assign in_stat.thr_high = thr_high_q;
	assign out0_stat.thr_low = thr_low_q;
	assign out0_stat.thr_high = thr_high_q;
	assign out1_stat.thr_low = thr_low_q;
	assign out1_stat.thr_high = thr_high_q;

	assign running = (state == CTRL_IDLE) || (state == CTRL_ACTIVE);

	// Almost full ends at full, so full keeps pause up
	assign pause = running && (in_stat.almost_full || in_stat.full);
	assign active = (state == CTRL_ACTIVE);

endmodule

// ==== hdl/router_top.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module router_top
	import router_pkg::*;
(
	input  logic clk,
	input  logic reset_L,
	input  logic push,
	input  word_t data_in,
	output logic pause,
	input  lvl_t thr_low_in,
	input  lvl_t thr_high_in,
	input  logic pop0,
	input  logic pop1,
	output word_t data_out0,
	output word_t data_out1,
	output logic empty0,
	output logic empty1,
	output logic active,
	output logic error_fifo
);

	word_t head;
	word_t demux_word;
	logic head_pop;
	logic push0;
	logic push1;
	logic credit_ret0;
	logic credit_ret1;

	fifo_status_if in_stat();
	fifo_status_if out0_stat();
	fifo_status_if out1_stat();

	// Only a pop that really removes a word returns a credit
	assign credit_ret0 = pop0 && !out0_stat.empty;
	assign credit_ret1 = pop1 && !out1_stat.empty;

	assign empty0 = out0_stat.empty;
	assign empty1 = out1_stat.empty;

	fifo #(.DEPTH(`ROUTER_DEPTH)) in_fifo (
		.clk      (clk),
		.reset_L  (reset_L),
		.push     (push),
		.pop      (head_pop),
		.data_in  (data_in),
		.data_out (head),
		.stat     (in_stat.fifo)
	);

	class_demux demux_i (
		.clk         (clk),
		.reset_L     (reset_L),
		.head        (head),
		.head_empty  (in_stat.empty),
		.head_pop    (head_pop),
		.push0       (push0),
		.push1       (push1),
		.word_out    (demux_word),
		.credit_ret0 (credit_ret0),
		.credit_ret1 (credit_ret1)
	);

	fifo #(.DEPTH(`ROUTER_DEPTH)) out0_fifo (
		.clk      (clk),
		.reset_L  (reset_L),
		.push     (push0),
		.pop      (pop0),
		.data_in  (demux_word),
		.data_out (data_out0),
		.stat     (out0_stat.fifo)
	);

	fifo #(.DEPTH(`ROUTER_DEPTH)) out1_fifo (
		.clk      (clk),
		.reset_L  (reset_L),
		.push     (push1),
		.pop      (pop1),
		.data_in  (demux_word),
		.data_out (data_out1),
		.stat     (out1_stat.fifo)
	);

	flow_ctrl ctrl_i (
		.clk         (clk),
		.reset_L     (reset_L),
		.thr_low_in  (thr_low_in),
		.thr_high_in (thr_high_in),
		.in_stat     (in_stat.ctrl),
		.out0_stat   (out0_stat.ctrl),
		.out1_stat   (out1_stat.ctrl),
		.pause       (pause),
		.active      (active),
		.error_fifo  (error_fifo)
	);

endmodule

// ==== test/router_asserts.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module router_asserts
	import router_pkg::*;
(
	input logic clk,
	input logic reset_L,
	input logic push0,
	input logic push1,
	input logic full0,
	input logic full1,
	input lvl_t credit0,
	input lvl_t credit1,
	input logic head_empty
);

	localparam lvl_t MAX_CNT = lvl_t'(`ROUTER_DEPTH);

	int unsigned fails = 0;	// Assertion failures so far

	// Credits must follow the real free slots of each output FIFO
	a_room: assert property (@(posedge clk) disable iff (!reset_L)
		!(push0 && full0) && !(push1 && full1))
		else begin
			fails++;
			$error("Output FIFO pushed while full");
		end

	a_cnt_max: assert property (@(posedge clk) disable iff (!reset_L)
		(credit0 <= MAX_CNT) && (credit1 <= MAX_CNT))
		else begin
			fails++;
			$error("Credit above FIFO depth: %0d %0d", credit0, credit1);
		end

	a_src: assert property (@(posedge clk) disable iff (!reset_L)
		(push0 || push1) |-> !head_empty)
		else begin
			fails++;
			$error("Push issued while the input FIFO was empty");
		end

endmodule

// Demux pushes seen against the flags of the FIFOs around it
bind router_top router_asserts router_chk (.clk, .reset_L, .push0, .push1,
	.full0(out0_stat.full), .full1(out1_stat.full),
	.credit0(demux_i.credit0), .credit1(demux_i.credit1),
	.head_empty(in_stat.empty));

// ==== test/router_tb.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module router_tb
	import router_pkg::*;
();

	logic clk;
	logic reset_L;
	logic push;
	word_t data_in;
	lvl_t thr_low_in;
	lvl_t thr_high_in;
	logic pop0;
	logic pop1;
	logic pause;
	word_t data_out0;
	word_t data_out1;
	logic empty0;
	logic empty1;
	logic active;
	logic error_fifo;
	int seed;
	word_t q0[$];	// Expected words per class, oldest first
	word_t q1[$];

	router_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Route is set by the top bit alone
	function automatic void model_accept(input word_t w);
		if (w[`ROUTER_WORD_W-1]) q1.push_back(w);
		else q0.push_back(w);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic apply_reset();
		push = 1'b0;
		reset_L = 1'b0;
		repeat (8) @(negedge clk);
		reset_L = 1'b1;
	endtask

	// Pop whatever shows until the model is empty and the router is idle
	task automatic drain_outputs(input string what);
		int n;
		n = 0;
		push = 1'b0;
		while (q0.size() != 0 || q1.size() != 0 || active) begin
			if (n == 200) abort_run({"Outputs never drained after ", what});
			pop0 = !empty0;
			pop1 = !empty1;
			n++;
			@(negedge clk);
		end
		pop0 = 1'b0;
		pop1 = 1'b0;
		compare_value("pause", pause, 1'b0);
		compare_value("error_fifo", error_fifo, 1'b0);
	endtask

	// One class only and no pops, so credits run out and the input FIFO backs up
	task automatic stall_class(input logic cls);
		int pushes;
		word_t w;
		pushes = 0;
		while (!pause) begin
			if (pushes == 40) abort_run("Pause never rose while one class was blocked");
			w = word_t'($random(seed));
			w[`ROUTER_WORD_W-1] = cls;
			push = 1'b1;
			data_in = w;
			model_accept(w);
			pushes++;
			@(negedge clk);
		end
		push = 1'b0;
		compare_value("pushes before pause", pushes, `ROUTER_DEPTH + thr_high_in);
		compare_value("active", active, 1'b1);
		compare_value("error_fifo", error_fifo, 1'b0);
	endtask

	task automatic wait_error(input string cause);
		int n;
		n = 0;
		while (!error_fifo) begin
			if (n == 10) abort_run({"error_fifo never rose after ", cause});
			n++;
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		compare_value("error_fifo", error_fifo, 1'b1);	// Sticky
	endtask

	// Each real output pop must match the front of its queue
	always @(posedge clk) begin
		if (reset_L && pop0 && !empty0) begin
			if (q0.size() == 0) abort_run("Output 0 gave a word that was never sent to it");
			else compare_value("data_out0", data_out0, q0.pop_front());
		end
		if (reset_L && pop1 && !empty1) begin
			if (q1.size() == 0) abort_run("Output 1 gave a word that was never sent to it");
			else compare_value("data_out1", data_out1, q1.pop_front());
		end
	end

	// Stop at the first bound assertion that fires
	always @(negedge clk) begin
		if (DUT.router_chk.fails != 0) abort_run("A bound assertion failed");
	end

	initial begin
		logic [31:0] r;
		int n;
		seed = 32'h1ef2_747f;
		data_in = '0;
		pop0 = 1'b0;
		pop1 = 1'b0;
		thr_low_in = 4'd2;
		thr_high_in = 4'd6;
		apply_reset();
		compare_value("empty0", empty0, 1'b1);
		compare_value("empty1", empty1, 1'b1);
		compare_value("pause", pause, 1'b0);
		compare_value("active", active, 1'b0);
		compare_value("error_fifo", error_fifo, 1'b0);
		repeat (2) @(negedge clk);	// Thresholds latched, controller idle
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			push = !pause && r[0];
			data_in = r[9:4];
			pop0 = !empty0 && r[1];
			pop1 = !empty1 && r[2];
			if (push) model_accept(data_in);
			@(negedge clk);
		end
		drain_outputs("random traffic");
		stall_class(1'b1);
		drain_outputs("class 1 stall");
		stall_class(1'b0);
		drain_outputs("class 0 stall");
		pop0 = 1'b1;	// Output 0 is empty here
		@(negedge clk);
		pop0 = 1'b0;
		wait_error("a pop of an empty output");
		apply_reset();
		compare_value("error_fifo", error_fifo, 1'b0);
		// Source ignores pause until the input FIFO overflows
		push = 1'b1;
		data_in = 6'h0a;
		repeat (2 * `ROUTER_DEPTH + 4) @(negedge clk);
		push = 1'b0;
		wait_error("an input overflow");
		apply_reset();
		compare_value("error_fifo", error_fifo, 1'b0);
		n = DUT.router_chk.fails;
		if (n == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("Bound assertions failed %0d times", n);
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/router_pkg.sv
hdl/fifo_status_if.sv
hdl/dual_port_memory.sv
hdl/fifo.sv
hdl/class_demux.sv
hdl/flow_ctrl.sv
hdl/router_top.sv
test/router_asserts.sv
test/router_tb.sv
